//--- src/uart_pkg.sv
package uart_pkg;

    // Bus data word
    typedef logic [31:0] word_t;

    // Bit period in clock cycles, 4 or more
    typedef logic [23:0] divider_t;

    typedef enum logic [1:0] {
        DATA_FIVE  = 2'd0,
        DATA_SIX   = 2'd1,
        DATA_SEVEN = 2'd2,
        DATA_EIGHT = 2'd3
    } data_bits_t;

    typedef enum logic [1:0] {
        PARITY_NONE = 2'd0,
        PARITY_EVEN = 2'd1,
        PARITY_ODD  = 2'd2
    } parity_t;

    typedef enum logic {
        STOP_ONE = 1'b0,
        STOP_TWO = 1'b1
    } stop_t;

    // Register ports on the bus
    typedef enum logic [3:0] {
        PORT_CONFIG = 4'd0,
        PORT_STATUS = 4'd1,
        PORT_READ   = 4'd2,
        PORT_WRITE  = 4'd3
    } port_t;

    // Status word bit positions
    localparam int unsigned STAT_RX_READY   = 0;
    localparam int unsigned STAT_TX_FULL    = 1;
    localparam int unsigned STAT_TX_IDLE    = 2;
    localparam int unsigned STAT_PARITY_ERR = 3;
    localparam int unsigned STAT_FRAME_ERR  = 4;
    localparam int unsigned STAT_OVERRUN    = 5;

    // 16 entries per FIFO
    localparam int unsigned FIFO_ADDR_WIDTH = 4;

    // 8-N-1, 115200 baud from 50 MHz
    localparam word_t CONFIG_RESET = {
        divider_t'(434),
        3'b000,
        STOP_ONE,
        PARITY_NONE,
        DATA_EIGHT
    };

endpackage

//--- src/uart_fifo.sv
`timescale 1ns/1ps

module uart_fifo #(
    parameter int DATA_WIDTH = 8,
    parameter int ADDR_WIDTH = 4
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  push_i,
    input  logic [DATA_WIDTH-1:0] wr_data_i,
    input  logic                  pop_i,
    output logic [DATA_WIDTH-1:0] rd_data_o,
    output logic                  rd_valid_o,
    output logic                  full_o
);

    localparam logic [ADDR_WIDTH:0] DEPTH = {1'b1, {ADDR_WIDTH{1'b0}}};

    logic [DATA_WIDTH-1:0] mem [1 << ADDR_WIDTH];

    // Extra MSB tells full from empty
    logic [ADDR_WIDTH:0] wr_ptr;
    logic [ADDR_WIDTH:0] rd_ptr;
    logic [ADDR_WIDTH:0] level;
    logic                do_push;
    logic                do_pop;

    assign level      = wr_ptr - rd_ptr;
    assign full_o     = (level == DEPTH);
    assign rd_valid_o = (level != '0);

    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && rd_valid_o;

    // Show-ahead head
    assign rd_data_o = mem[rd_ptr[ADDR_WIDTH-1:0]];

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem[wr_ptr[ADDR_WIDTH-1:0]] <= wr_data_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Occupancy stays within the buffer over any push/pop sequence
    assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        level <= DEPTH
    ) else $error("uart_fifo: pointer distance exceeds depth");

endmodule

//--- src/uart_tx.sv
`timescale 1ns/1ps

module uart_tx
    import uart_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  data_bits_t data_bits_i,
    input  parity_t    parity_i,
    input  stop_t      stop_i,
    input  divider_t   divider_i,
    input  logic [7:0] rd_data_i,
    input  logic       rd_valid_i,
    output logic       pop_o,
    output logic       txd_o,
    output logic       idle_o
);

    typedef enum logic [2:0] {IDLE, START, DATA, PARITY, STOP} state_t;

    state_t     state;
    logic       pop_r;
    logic       txd_r;
    divider_t   bit_timer;
    logic [2:0] bit_index;
    logic [2:0] last_index;
    logic       parity_acc;
    logic [7:0] shift_r;
    data_bits_t data_bits_r;
    parity_t    parity_r;
    stop_t      stop_r;
    divider_t   divider_r;

    assign pop_o      = pop_r;
    assign txd_o      = txd_r;
    assign idle_o     = (state == IDLE);
    assign last_index = {1'b0, data_bits_r} + 3'd4;

    // Byte and frame format, taken with the pop
    always_ff @(posedge clk_i) begin
        if (state == IDLE && pop_r) begin
            shift_r     <= rd_data_i;
            data_bits_r <= data_bits_i;
            parity_r    <= parity_i;
            stop_r      <= stop_i;
            divider_r   <= divider_i;
        end else if (bit_timer == '0 && (state == START || state == DATA)) begin
            shift_r <= shift_r >> 1;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state      <= IDLE;
            pop_r      <= 1'b0;
            txd_r      <= 1'b1;
            bit_timer  <= '0;
            bit_index  <= '0;
            parity_acc <= 1'b0;
        end else begin
            pop_r <= 1'b0;
            if (state == IDLE) begin
                txd_r <= 1'b1;
                if (pop_r) begin
                    state     <= START;
                    txd_r     <= 1'b0;
                    bit_timer <= divider_i - 1'b1;
                end else if (rd_valid_i) begin
                    pop_r <= 1'b1;
                end
            end else if (bit_timer != '0) begin
                bit_timer <= bit_timer - 1'b1;
            end else begin
                bit_timer <= divider_r - 1'b1;
                case (state)
                    START: begin
                        state      <= DATA;
                        txd_r      <= shift_r[0];
                        parity_acc <= shift_r[0];
                        bit_index  <= '0;
                    end
                    DATA: begin
                        if (bit_index != last_index) begin
                            bit_index  <= bit_index + 1'b1;
                            txd_r      <= shift_r[0];
                            parity_acc <= parity_acc ^ shift_r[0];
                        end else if (parity_r == PARITY_NONE) begin
                            state     <= STOP;
                            txd_r     <= 1'b1;
                            bit_index <= '0;
                        end else begin
                            state <= PARITY;
                            // Odd parity inverts the data XOR
                            txd_r <= parity_acc ^ (parity_r == PARITY_ODD);
                        end
                    end
                    PARITY: begin
                        state     <= STOP;
                        txd_r     <= 1'b1;
                        bit_index <= '0;
                    end
                    STOP: begin
                        if (stop_r == STOP_TWO && bit_index == '0) begin
                            bit_index <= 3'd1;
                        end else begin
                            state <= IDLE;
                        end
                    end
                    default: state <= IDLE;
                endcase
            end
        end
    end

    assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        state == IDLE |-> txd_o
    ) else $error("uart_tx: line low while idle");

    // Pop lands one cycle after the FIFO was seen valid
    assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        pop_o |-> rd_valid_i
    ) else $error("uart_tx: pop from empty FIFO");

endmodule

//--- src/uart_rx.sv
`timescale 1ns/1ps

module uart_rx
    import uart_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  data_bits_t data_bits_i,
    input  parity_t    parity_i,
    input  stop_t      stop_i,
    input  divider_t   divider_i,
    input  logic       rxd_i,
    output logic [7:0] data_o,
    output logic       data_valid_o,
    output logic       parity_err_o,
    output logic       frame_err_o
);

    typedef enum logic [2:0] {IDLE, START, DATA, PARITY, STOP} state_t;

    state_t     state;
    logic       rxd_meta;
    logic       rxd_sync;
    logic       rxd_prev;
    logic       start_edge;
    divider_t   bit_timer;
    logic [2:0] bit_index;
    logic [2:0] last_index;
    logic       parity_acc;
    logic       parity_bad;
    logic       data_valid_r;
    logic       parity_err_r;
    logic       frame_err_r;
    logic [7:0] shift_r;
    logic [7:0] data_out_r;
    logic [1:0] align;
    data_bits_t data_bits_r;
    parity_t    parity_r;
    divider_t   divider_r;

    assign data_o       = data_out_r;
    assign data_valid_o = data_valid_r;
    assign parity_err_o = parity_err_r;
    assign frame_err_o  = frame_err_r;

    assign start_edge = rxd_prev && !rxd_sync;
    assign last_index = {1'b0, data_bits_r} + 3'd4;
    // Short bytes arrive in the top bits of the shifter
    assign align      = 2'd3 - data_bits_r;

    // Two-flop synchroniser plus edge history
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
            rxd_prev <= 1'b1;
        end else begin
            rxd_meta <= rxd_i;
            rxd_sync <= rxd_meta;
            rxd_prev <= rxd_sync;
        end
    end

    always_ff @(posedge clk_i) begin
        if (state == IDLE && start_edge) begin
            data_bits_r <= data_bits_i;
            parity_r    <= parity_i;
            divider_r   <= divider_i;
        end
        if (state == DATA && bit_timer == '0) begin
            shift_r <= {rxd_sync, shift_r[7:1]};
        end
        if (state == STOP && bit_timer == '0) begin
            data_out_r <= shift_r >> align;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state        <= IDLE;
            bit_timer    <= '0;
            bit_index    <= '0;
            parity_acc   <= 1'b0;
            parity_bad   <= 1'b0;
            data_valid_r <= 1'b0;
            parity_err_r <= 1'b0;
            frame_err_r  <= 1'b0;
        end else begin
            data_valid_r <= 1'b0;
            if (state == IDLE) begin
                if (start_edge) begin
                    state      <= START;
                    bit_timer  <= (divider_i >> 1) - 1'b1;
                    parity_acc <= 1'b0;
                    parity_bad <= 1'b0;
                end
            end else if (bit_timer != '0) begin
                bit_timer <= bit_timer - 1'b1;
            end else begin
                bit_timer <= divider_r - 1'b1;
                case (state)
                    START: begin
                        // Glitch if the line is back high at mid start bit
                        state     <= rxd_sync ? IDLE : DATA;
                        bit_index <= '0;
                    end
                    DATA: begin
                        parity_acc <= parity_acc ^ rxd_sync;
                        bit_index  <= bit_index + 1'b1;
                        if (bit_index == last_index) begin
                            state <= (parity_r == PARITY_NONE) ? STOP : PARITY;
                        end
                    end
                    PARITY: begin
                        state      <= STOP;
                        parity_bad <= (parity_acc ^ rxd_sync) != (parity_r == PARITY_ODD);
                    end
                    STOP: begin
                        state        <= IDLE;
                        data_valid_r <= 1'b1;
                        parity_err_r <= parity_bad;
                        frame_err_r  <= !rxd_sync;
                    end
                    default: state <= IDLE;
                endcase
            end
        end
    end

    assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        data_valid_o |=> !data_valid_o
    ) else $error("uart_rx: data_valid_o held for two cycles");

endmodule

//--- src/uart.sv
`timescale 1ns/1ps

module uart
    import uart_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       rxd_i,
    input  logic       chip_select_i,
    input  logic [3:0] addr_i,
    input  logic       read_enable_i,
    input  word_t      write_data_i,
    input  logic [3:0] write_mask_i,
    output logic       interrupt_o,
    output logic       txd_o,
    output word_t      read_data_o
);

    port_t      port;
    word_t      config_r;
    word_t      read_data_r;
    word_t      status_word;
    data_bits_t data_bits;
    parity_t    parity;
    stop_t      stop;
    divider_t   divider;

    logic       bus_read;
    logic       bus_write;
    logic       status_read;
    logic       tx_push;
    logic       rx_pop;

    logic [7:0] rx_byte;
    logic       rx_byte_valid;
    logic       rx_parity_err;
    logic       rx_frame_err;
    logic [7:0] rx_head;
    logic       rx_head_valid;
    logic       rx_full;

    logic [7:0] tx_head;
    logic       tx_head_valid;
    logic       tx_full;
    logic       tx_pop;
    logic       tx_idle;

    logic       parity_err_r;
    logic       frame_err_r;
    logic       overrun_r;

    assign port      = port_t'(addr_i);
    assign data_bits = data_bits_t'(config_r[1:0]);
    assign parity    = parity_t'(config_r[3:2]);
    assign stop      = stop_t'(config_r[4]);
    assign divider   = config_r[31:8];

    assign bus_read    = chip_select_i && read_enable_i;
    assign bus_write   = chip_select_i && !read_enable_i;
    assign status_read = bus_read && port == PORT_STATUS;
    assign rx_pop      = bus_read && port == PORT_READ && rx_head_valid;
    assign tx_push     = bus_write && port == PORT_WRITE && write_mask_i[0];

    assign interrupt_o = rx_head_valid;
    assign read_data_o = read_data_r;

    always_comb begin
        status_word                  = '0;
        status_word[STAT_RX_READY]   = rx_head_valid;
        status_word[STAT_TX_FULL]    = tx_full;
        status_word[STAT_TX_IDLE]    = !tx_head_valid && tx_idle;
        status_word[STAT_PARITY_ERR] = parity_err_r;
        status_word[STAT_FRAME_ERR]  = frame_err_r;
        status_word[STAT_OVERRUN]    = overrun_r;
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            config_r <= CONFIG_RESET;
        end else if (bus_write && port == PORT_CONFIG) begin
            for (int i = 0; i < 4; i++) begin
                if (write_mask_i[i]) begin
                    config_r[8*i +: 8] <= write_data_i[8*i +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            read_data_r <= '0;
        end else if (bus_read) begin
            case (port)
                PORT_CONFIG: read_data_r <= config_r;
                PORT_STATUS: read_data_r <= status_word;
                PORT_READ:   read_data_r <= {23'b0, rx_head_valid, rx_head_valid ? rx_head : 8'h00};
                default:     read_data_r <= '0;
            endcase
        end
    end

    // Sticky flags, a new event beats the clear-on-read
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            parity_err_r <= 1'b0;
            frame_err_r  <= 1'b0;
            overrun_r    <= 1'b0;
        end else begin
            if (status_read) begin
                parity_err_r <= 1'b0;
                frame_err_r  <= 1'b0;
                overrun_r    <= 1'b0;
            end
            if (rx_byte_valid && rx_parity_err) begin
                parity_err_r <= 1'b1;
            end
            if (rx_byte_valid && rx_frame_err) begin
                frame_err_r <= 1'b1;
            end
            if ((tx_push && tx_full) || (rx_byte_valid && rx_full)) begin
                overrun_r <= 1'b1;
            end
        end
    end

    uart_rx i_rx (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .data_bits_i  (data_bits),
        .parity_i     (parity),
        .stop_i       (),
        .divider_i    (divider),
        .rxd_i        (rxd_i),
        .data_o       (rx_byte),
        .data_valid_o (rx_byte_valid),
        .parity_err_o (rx_parity_err),
        .frame_err_o  (rx_frame_err)
    );

    uart_fifo #(
        .DATA_WIDTH (8),
        .ADDR_WIDTH (FIFO_ADDR_WIDTH)
    ) rx_fifo (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .push_i     (rx_byte_valid),
        .wr_data_i  (rx_byte),
        .pop_i      (rx_pop),
        .rd_data_o  (rx_head),
        .rd_valid_o (rx_head_valid),
        .full_o     (rx_full)
    );

    uart_fifo #(
        .DATA_WIDTH (8),
        .ADDR_WIDTH (FIFO_ADDR_WIDTH)
    ) tx_fifo (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .push_i     (tx_push),
        .wr_data_i  (write_data_i[7:0]),
        .pop_i      (tx_pop),
        .rd_data_o  (tx_head),
        .rd_valid_o (tx_head_valid),
        .full_o     (tx_full)
    );

    uart_tx i_tx (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .data_bits_i (data_bits),
        .parity_i    (parity),
        .stop_i      (stop),
        .divider_i   (divider),
        .rd_data_i   (tx_head),
        .rd_valid_i  (tx_head_valid),
        .pop_o       (tx_pop),
        .txd_o       (txd_o),
        .idle_o      (tx_idle)
    );

endmodule

//--- verification/uart_tb.sv
`timescale 1ns/1ps

module uart_tb
    import uart_pkg::*;
();

    localparam int CLK_HALF       = 50;
    localparam int TEST_DIV       = 8;
    // Frames in all tests
    localparam int TOTAL_FRAMES   = 49;
    // Longest frame of 12 bits with a fourfold margin
    localparam int TIMEOUT_CYCLES = TOTAL_FRAMES * 12 * TEST_DIV * 4 + 4000;

    logic  clk_i = 1'b0;
    logic  rst_n_i;
    logic  chip_select_i;
    logic  [3:0] addr_i;
    logic  read_enable_i;
    word_t write_data_i;
    logic  [3:0] write_mask_i;
    logic  interrupt_o;
    logic  txd_o;
    word_t read_data_o;
    logic  rxd_i;
    logic  loopback;
    logic  drv_line;

    integer seed = 32'h382;
    string  test_name;
    int     frame_count;
    logic [1:0] cfg_bits;
    logic [1:0] cfg_par;
    logic       cfg_stop;
    int         cfg_div;
    logic [11:0] exp_frames[$];
    logic [11:0] act_frames[$];
    word_t       exp_reads[$];
    word_t       act_reads[$];

    assign rxd_i = loopback ? txd_o : drv_line;

    uart i_dut (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .rxd_i         (rxd_i),
        .chip_select_i (chip_select_i),
        .addr_i        (addr_i),
        .read_enable_i (read_enable_i),
        .write_data_i  (write_data_i),
        .write_mask_i  (write_mask_i),
        .interrupt_o   (interrupt_o),
        .txd_o         (txd_o),
        .read_data_o   (read_data_o)
    );

    initial begin
        forever #CLK_HALF clk_i = ~clk_i;
    end

    function automatic int frame_len(logic [1:0] bits, logic [1:0] par, logic stop);
        return 1 + (bits + 5) + ((par != 2'd0) ? 1 : 0) + (stop ? 2 : 1);
    endfunction

    // Line bits in time order with the start bit in bit 0
    function automatic logic [11:0] expected_frame(logic [7:0] b, logic [1:0] bits,
                                                   logic [1:0] par, logic stop);
        logic [11:0] f;
        int          n;
        logic        ones;
        f    = '1;
        n    = bits + 5;
        ones = 1'b0;
        f[0] = 1'b0;
        for (int i = 0; i < n; i++) begin
            f[1 + i] = b[i];
            ones     = ones ^ b[i];
        end
        if (par == 2'd1) begin
            f[1 + n] = ones;
        end else if (par == 2'd2) begin
            f[1 + n] = ~ones;
        end
        return f;
    endfunction

    function automatic logic [7:0] expected_byte(logic [7:0] b, logic [1:0] bits);
        return b & ((8'd1 << (bits + 5)) - 8'd1);
    endfunction

    task automatic fail_check(string name, word_t exp, word_t act);
        $display("FAIL %s expected %h actual %h", name, exp, act);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_value(string name, word_t exp, word_t act);
        assert (exp == act) else fail_check(name, exp, act);
    endtask

    task automatic bus_write(logic [3:0] addr, word_t data, logic [3:0] mask);
        @(posedge clk_i);
        chip_select_i <= 1'b1;
        read_enable_i <= 1'b0;
        addr_i        <= addr;
        write_data_i  <= data;
        write_mask_i  <= mask;
        @(posedge clk_i);
        chip_select_i <= 1'b0;
    endtask

    task automatic bus_read(logic [3:0] addr, output word_t data);
        @(posedge clk_i);
        chip_select_i <= 1'b1;
        read_enable_i <= 1'b1;
        addr_i        <= addr;
        @(posedge clk_i);
        chip_select_i <= 1'b0;
        read_enable_i <= 1'b0;
        @(negedge clk_i);
        data = read_data_o;
    endtask

    task automatic set_config(logic [1:0] bits, logic [1:0] par, logic stop, int div);
        cfg_bits = bits;
        cfg_par  = par;
        cfg_stop = stop;
        cfg_div  = div;
        bus_write(PORT_CONFIG, {divider_t'(div), 3'b000, stop, par, bits}, 4'hf);
    endtask

    task automatic send_byte(logic [7:0] b, bit expect_frame, bit expect_read);
        bus_write(PORT_WRITE, {24'h0, b}, 4'h1);
        if (expect_frame) begin
            exp_frames.push_back(expected_frame(b, cfg_bits, cfg_par, cfg_stop));
        end
        if (expect_read) begin
            exp_reads.push_back({23'h0, 1'b1, expected_byte(b, cfg_bits)});
        end
    endtask

    task automatic read_rx(word_t exp);
        word_t w;
        exp_reads.push_back(exp);
        bus_read(PORT_READ, w);
        act_reads.push_back(w);
    endtask

    task automatic wait_tx_idle();
        word_t w;
        do begin
            bus_read(PORT_STATUS, w);
        end while (!w[STAT_TX_IDLE]);
    endtask

    // Received data shows up as the interrupt
    task automatic wait_rx_ready();
        @(negedge clk_i);
        while (interrupt_o !== 1'b1) begin
            @(negedge clk_i);
        end
    endtask

    // Serial driver that can corrupt parity or the stop bit
    task automatic drive_frame(logic [7:0] b, bit bad_parity, bit low_stop);
        logic [11:0] f;
        int          n;
        n = frame_len(cfg_bits, cfg_par, cfg_stop);
        f = expected_frame(b, cfg_bits, cfg_par, cfg_stop);
        if (bad_parity) f[cfg_bits + 6] = ~f[cfg_bits + 6];
        if (low_stop) f[n - 1] = 1'b0;
        @(posedge clk_i);
        for (int i = 0; i < n; i++) begin
            drv_line <= f[i];
            repeat (cfg_div) @(posedge clk_i);
        end
        drv_line <= 1'b1;
    endtask

    // Monitor samples txd_o mid-bit
    initial begin
        logic [11:0] f;
        int          n;
        frame_count = 0;
        forever begin
            do @(negedge clk_i); while (txd_o !== 1'b0);
            n = frame_len(cfg_bits, cfg_par, cfg_stop);
            f = '1;
            repeat (cfg_div / 2) @(negedge clk_i);
            f[0] = txd_o;
            for (int i = 1; i < n; i++) begin
                repeat (cfg_div) @(negedge clk_i);
                f[i] = txd_o;
            end
            act_frames.push_back(f);
            frame_count++;
        end
    end

    // Compare process
    initial begin
        logic [11:0] ef;
        logic [11:0] af;
        forever begin
            @(negedge clk_i);
            while (act_frames.size() > 0) begin
                af = act_frames.pop_front();
                assert (exp_frames.size() > 0) else begin
                    $display("Frame on txd_o in %s with nothing written", test_name);
                    $display("SOME TESTS FAILED");
                    $fatal(1);
                end
                ef = exp_frames.pop_front();
                check_value({test_name, " frame"}, ef, af);
            end
            while (act_reads.size() > 0) begin
                check_value({test_name, " rx read"}, exp_reads.pop_front(), act_reads.pop_front());
            end
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk_i);
        $display("Timeout, the simulation did not complete in time");
        $display("SOME TESTS FAILED");
        $fatal(1);
    end

    initial begin
        word_t w;
        word_t merged;
        int    base;
        rst_n_i       = 1'b0;
        chip_select_i = 1'b0;
        addr_i        = '0;
        read_enable_i = 1'b0;
        write_data_i  = '0;
        write_mask_i  = '0;
        loopback      = 1'b0;
        drv_line      = 1'b1;
        cfg_bits      = 2'd3;
        cfg_par       = 2'd0;
        cfg_stop      = 1'b0;
        cfg_div       = 434;
        repeat (16) @(posedge clk_i);
        rst_n_i <= 1'b1;

        test_name = "config";
        bus_read(PORT_CONFIG, w);
        check_value(test_name, CONFIG_RESET, w);
        bus_write(PORT_CONFIG, 32'ha5c3_1e2d, 4'b0101);
        merged = {CONFIG_RESET[31:24], 8'hc3, CONFIG_RESET[15:8], 8'h2d};
        bus_read(PORT_CONFIG, w);
        check_value(test_name, merged, w);

        test_name = "tx_format";
        for (int k = 0; k < 6; k++) begin
            case (k)
                0: set_config(2'd3, 2'd0, 1'b0, TEST_DIV);
                1: set_config(2'd0, 2'd1, 1'b0, TEST_DIV);
                2: set_config(2'd3, 2'd2, 1'b1, TEST_DIV);
                3: set_config(2'd0, 2'd0, 1'b1, TEST_DIV);
                4: set_config(2'd3, 2'd1, 1'b1, TEST_DIV);
                default: set_config(2'd0, 2'd2, 1'b0, TEST_DIV);
            endcase
            repeat (4) send_byte($random(seed), 1'b1, 1'b0);
            wait_tx_idle();
        end

        test_name = "loopback";
        loopback  = 1'b1;
        set_config(2'd2, 2'd2, 1'b1, TEST_DIV);
        repeat (6) send_byte($random(seed), 1'b1, 1'b1);
        wait_tx_idle();
        for (int i = 0; i < 6; i++) begin
            check_value({test_name, " interrupt"}, 1, interrupt_o);
            bus_read(PORT_READ, w);
            act_reads.push_back(w);
        end
        check_value({test_name, " interrupt"}, 0, interrupt_o);
        read_rx(32'h0);

        test_name = "rx_errors";
        loopback  = 1'b0;
        set_config(2'd3, 2'd1, 1'b0, TEST_DIV);
        drive_frame(8'h5a, 1'b1, 1'b0);
        wait_rx_ready();
        bus_read(PORT_STATUS, w);
        check_value({test_name, " parity"}, 32'h08, w & 32'h18);
        read_rx(32'h15a);
        drive_frame(8'hc3, 1'b0, 1'b1);
        wait_rx_ready();
        bus_read(PORT_STATUS, w);
        check_value({test_name, " frame"}, 32'h10, w & 32'h18);
        read_rx(32'h1c3);
        bus_read(PORT_STATUS, w);
        check_value({test_name, " cleared"}, 32'h0, w & 32'h18);

        test_name = "overrun";
        set_config(2'd3, 2'd0, 1'b0, TEST_DIV);
        bus_read(PORT_STATUS, w);
        base = frame_count;
        for (int i = 0; i < 18; i++) begin
            send_byte($random(seed), i < 17, 1'b0);
        end
        bus_read(PORT_STATUS, w);
        check_value({test_name, " tx_full"}, 1, w[STAT_TX_FULL]);
        check_value({test_name, " flag"}, 1, w[STAT_OVERRUN]);
        wait_tx_idle();
        repeat (4) @(posedge clk_i);
        check_value({test_name, " frames"}, 17, frame_count - base);

        repeat (4) @(posedge clk_i);
        if (exp_frames.size() == 0 && exp_reads.size() == 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            $display("Expected frames or reads never arrived");
            $display("SOME TESTS FAILED");
            $fatal(1);
        end
    end

endmodule

//--- tb.f
src/uart_pkg.sv
src/uart_fifo.sv
src/uart_tx.sv
src/uart_rx.sv
src/uart.sv
verification/uart_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the UART testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module uart_tb -f tb.f -o uart_sim &&
./obj_dir/uart_sim | tee /dev/stderr | grep -q "ALL TESTS PASSED" &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed"; exit 1; }
